// ==== logic/residue_pkg.sv ====
package residue_pkg;

  // Operand width
  localparam int unsigned XW = 64;

  // Modulus and residue width, a residue is always below m
  localparam int unsigned MW = 32;

  // Width of the bit-length input
  localparam int unsigned BLW = 6;

  // Accepted bit-length range of the modulus
  localparam int unsigned BL_MIN = 3;
  localparam int unsigned BL_MAX = 32;

  // Form of the modulus as seen by the sequencer
  //   Mersenne  m = 2^k - 1, k = bl
  //   Fermat    m = 2^k + 1, k = bl - 1
  typedef enum logic [1:0] {
    FOLD_MERSENNE = 2'd0,
    FOLD_FERMAT   = 2'd1,
    FOLD_NONE     = 2'd2   // Unsupported modulus, no reduction
  } fold_kind_e;

endpackage

// ==== logic/chunk_stream_if.sv ====
`timescale 1ns/1ns

interface chunk_stream_if import residue_pkg::*; ();

  logic          beat;      // One valid chunk this cycle
  logic [MW-1:0] chunk;     // Zero-extended k-bit slice of the operand
  logic          first;     // First beat of a request
  logic          last;      // Final beat of a request
  fold_kind_e    kind;      // Stable from first beat until next request
  logic [MW-1:0] modulus;   // Latched modulus

  modport src (
    output beat, chunk, first, last, kind, modulus
  );

  modport fold (
    input beat, chunk, first, last, kind, modulus
  );

  // Residue stage only needs the request context
  modport sink (
    input kind, modulus
  );

endinterface

// ==== logic/fold_sequencer.sv ====
`timescale 1ns/1ns

module fold_sequencer import residue_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            start_i,
  input  logic [XW-1:0]   x_i,
  input  logic [MW-1:0]   m_i,
  input  logic [BLW-1:0]  m_bl_i,
  output logic            busy_o,
  chunk_stream_if.src     stream_o
);

  typedef enum logic [1:0] {
    IDLE,
    STREAM,
    DRAIN
  } state_e;

  state_e         state_q;
  state_e         state_d;
  logic           accept;
  logic           first_q;

  // Classification of the incoming modulus
  logic           bl_ok;
  logic [MW:0]    bl_pow;      // 2^bl in one extra bit so bl = 32 fits
  logic [MW-1:0]  ones_bl;     // 2^bl - 1
  logic [MW-1:0]  fermat_bl;   // 2^(bl-1) + 1
  fold_kind_e     kind_d;
  logic [BLW-1:0] k_d;
  logic [MW-1:0]  mask_d;

  // Latched request
  logic [XW-1:0]  x_q;
  logic [MW-1:0]  mod_q;
  fold_kind_e     kind_q;
  logic [BLW-1:0] k_q;
  logic [MW-1:0]  mask_q;
  logic [XW-1:0]  x_rest;
  logic           last_beat;

  assign accept = start_i && (state_q == IDLE);

  assign bl_ok     = (m_bl_i >= BLW'(BL_MIN)) && (m_bl_i <= BLW'(BL_MAX));
  assign bl_pow    = (MW+1)'(1) << m_bl_i;
  assign ones_bl   = MW'(bl_pow - 1'b1);
  assign fermat_bl = MW'(bl_pow >> 1) | MW'(1);

  always_comb begin
    kind_d = FOLD_NONE;
    k_d    = m_bl_i;
    mask_d = '0;
    if (bl_ok && (m_i == ones_bl)) begin
      kind_d = FOLD_MERSENNE;
      mask_d = ones_bl;               // k = bl
    end else if (bl_ok && (m_i == fermat_bl)) begin
      kind_d = FOLD_FERMAT;
      k_d    = m_bl_i - 1'b1;         // k = bl - 1
      mask_d = MW'((bl_pow >> 1) - 1'b1);
    end
  end

  assign x_rest = x_q >> k_q;

  // Unsupported requests stop after a single beat
  assign last_beat = (x_rest == '0) || (kind_q == FOLD_NONE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_i) state_d = STREAM;
      STREAM:  if (last_beat) state_d = DRAIN;
      DRAIN:   state_d = IDLE;        // Folders report done here
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      first_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        first_q <= 1'b1;
      end else if (stream_o.beat) begin
        first_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      x_q    <= x_i;
      mod_q  <= m_i;
      kind_q <= kind_d;
      k_q    <= k_d;
      mask_q <= mask_d;
    end else if (stream_o.beat) begin
      x_q    <= x_rest;               // Drop the chunk just sent
    end
  end

  assign stream_o.beat    = (state_q == STREAM);
  assign stream_o.chunk   = x_q[MW-1:0] & mask_q;
  assign stream_o.first   = first_q;
  assign stream_o.last    = stream_o.beat && last_beat;
  assign stream_o.kind    = kind_q;
  assign stream_o.modulus = mod_q;

  assign busy_o = (state_q != IDLE);

  // Accepted start opens its run with first on the next cycle
  a_first_after_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |=> stream_o.beat && stream_o.first);

  // No gap and no second first inside a run
  a_first_once: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stream_o.beat && !stream_o.last |=> stream_o.beat && !stream_o.first);

  // Run ends on its single last beat
  a_last_once: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stream_o.beat && stream_o.last |=> !stream_o.beat);

endmodule

// ==== logic/mersenne_fold.sv ====
`timescale 1ns/1ns

module mersenne_fold import residue_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  chunk_stream_if.fold  stream_i,
  output logic [MW-1:0] residue_o,
  output logic          done_o
);

  logic [MW-1:0] acc_q;
  logic [MW-1:0] acc_d;
  logic [MW-1:0] base;
  logic [MW:0]   sum;
  logic          carry;
  logic          done_q;

  // First beat starts from zero, so the chunk is simply loaded
  assign base = stream_i.first ? '0 : acc_q;
  assign sum  = {1'b0, base} + {1'b0, stream_i.chunk};

  // Anything above the k-bit mask is the carry out of bit k
  assign carry = |(sum & ~{1'b0, stream_i.modulus});

  // End-around carry, 2^k is 1 mod m
  assign acc_d = (sum[MW-1:0] & stream_i.modulus) + MW'(carry);

  always_ff @(posedge clk_i) begin
    if (stream_i.beat) begin
      acc_q <= acc_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else begin
      done_q <= stream_i.beat && stream_i.last;
    end
  end

  assign residue_o = acc_q;   // All ones stands for zero
  assign done_o    = done_q;

  a_acc_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stream_i.beat && stream_i.kind == FOLD_MERSENNE |=> acc_q <= stream_i.modulus);

endmodule

// ==== logic/fermat_fold.sv ====
`timescale 1ns/1ns

module fermat_fold import residue_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  chunk_stream_if.fold  stream_i,
  output logic [MW-1:0] residue_o,
  output logic          done_o
);

  logic [MW-1:0] acc_q;
  logic [MW-1:0] base;
  logic          sub_q;      // Next beat has odd index
  logic          sub_now;
  logic [MW:0]   m_ext;
  logic [MW:0]   sum;
  logic [MW:0]   diff;
  logic [MW:0]   step;
  logic          done_q;

  // 2^k is -1 mod m, so odd chunks are subtracted
  assign sub_now = !stream_i.first && sub_q;
  assign base    = stream_i.first ? '0 : acc_q;
  assign m_ext   = {1'b0, stream_i.modulus};

  assign sum  = {1'b0, base} + {1'b0, stream_i.chunk};
  assign diff = {1'b0, base} - {1'b0, stream_i.chunk};

  // One correction by m is enough since each chunk is below m
  always_comb begin
    if (sub_now) begin
      step = diff[MW] ? diff + m_ext : diff;   // Borrow means negative
    end else begin
      step = (sum >= m_ext) ? sum - m_ext : sum;
    end
  end

  always_ff @(posedge clk_i) begin
    if (stream_i.beat) begin
      acc_q <= step[MW-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sub_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      if (stream_i.beat) begin
        sub_q <= !sub_now;
      end
      done_q <= stream_i.beat && stream_i.last;
    end
  end

  assign residue_o = acc_q;
  assign done_o    = done_q;

  a_residue_below_m: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stream_i.beat && stream_i.kind == FOLD_FERMAT |=> residue_o < stream_i.modulus);

endmodule

// ==== logic/residue_select.sv ====
`timescale 1ns/1ns

module residue_select import residue_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  chunk_stream_if.sink  stream_i,
  input  logic [MW-1:0] mers_residue_i,
  input  logic [MW-1:0] ferm_residue_i,
  input  logic          done_i,
  output logic [MW-1:0] result_o,
  output logic          valid_o,
  output logic          error_o
);

  logic [MW-1:0] result_d;
  logic          error_d;
  logic [MW-1:0] result_q;
  logic          valid_q;
  logic          error_q;

  always_comb begin
    result_d = '0;
    error_d  = 1'b0;
    case (stream_i.kind)
      FOLD_MERSENNE: begin
        // All ones is the second encoding of zero
        if (mers_residue_i == stream_i.modulus) begin
          result_d = '0;
        end else begin
          result_d = mers_residue_i;
        end
      end
      FOLD_FERMAT: begin
        result_d = ferm_residue_i;   // Already within 0 to m-1
      end
      default: begin
        error_d = 1'b1;              // Neither form, no reduction
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      result_q <= '0;
      valid_q  <= 1'b0;
      error_q  <= 1'b0;
    end else begin
      valid_q <= done_i;
      error_q <= done_i && error_d;
      if (done_i) begin
        result_q <= result_d;        // Held until the next request
      end
    end
  end

  assign result_o = result_q;
  assign valid_o  = valid_q;
  assign error_o  = error_q;

  a_result_below_m: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !error_o |-> result_o < stream_i.modulus);

endmodule

// ==== logic/residue_top.sv ====
`timescale 1ns/1ns

module residue_top import residue_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           start_i,
  input  logic [XW-1:0]  x_i,
  input  logic [MW-1:0]  m_i,
  input  logic [BLW-1:0] m_bl_i,
  output logic [MW-1:0]  result_o,
  output logic           valid_o,
  output logic           error_o,
  output logic           busy_o
);

  chunk_stream_if stream_if ();

  logic [MW-1:0] mers_residue;
  logic [MW-1:0] ferm_residue;
  logic          mers_done;

  fold_sequencer u_sequencer (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_i),
    .x_i      (x_i),
    .m_i      (m_i),
    .m_bl_i   (m_bl_i),
    .busy_o   (busy_o),
    .stream_o (stream_if)
  );

  mersenne_fold u_mersenne (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .stream_i  (stream_if),
    .residue_o (mers_residue),
    .done_o    (mers_done)
  );

  // Finishes in the same cycle as the Mersenne folder
  fermat_fold u_fermat (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .stream_i  (stream_if),
    .residue_o (ferm_residue),
    .done_o    ()
  );

  residue_select u_select (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .stream_i       (stream_if),
    .mers_residue_i (mers_residue),
    .ferm_residue_i (ferm_residue),
    .done_i         (mers_done),
    .result_o       (result_o),
    .valid_o        (valid_o),
    .error_o        (error_o)
  );

endmodule

// ==== bench/residue_tb.sv ====
`timescale 1ns/1ns

module residue_tb import residue_pkg::*; ();

  localparam int          CLK_PERIOD     = 8;
  localparam int          RESET_CYCLES   = 10;
  localparam logic [31:0] LCG_SEED       = 32'h630de3e1;
  localparam int          TIMEOUT_CYCLES = 200;
  localparam int          NUM_RANDOM     = 40;

  logic           clk_i;
  logic           rst_ni;
  logic           start_i;
  logic [XW-1:0]  x_i;
  logic [MW-1:0]  m_i;
  logic [BLW-1:0] m_bl_i;
  logic [MW-1:0]  result_o;
  logic           valid_o;
  logic           error_o;
  logic           busy_o;

  // Stimulus table, one entry per index across the four queues
  logic [XW-1:0]  tab_x[$];
  logic [MW-1:0]  tab_m[$];
  logic [BLW-1:0] tab_bl[$];
  logic           tab_err[$];

  logic [31:0]    lcg_state;
  int             err_count;
  int             timeout_count;

  residue_top dut_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_i),
    .x_i      (x_i),
    .m_i      (m_i),
    .m_bl_i   (m_bl_i),
    .result_o (result_o),
    .valid_o  (valid_o),
    .error_o  (error_o),
    .busy_o   (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw_random(output logic [31:0] r);
    lcg_state = lcg_next(lcg_state);
    r = lcg_state;
  endtask

  // Operand of random width up to 64 bits
  task automatic random_operand(output logic [XW-1:0] x);
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] sh;
    draw_random(hi);
    draw_random(lo);
    draw_random(sh);
    x = {hi, lo} >> sh[5:0];
  endtask

  // Inputs change and outputs are read 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_value(input string name, input logic [XW-1:0] got,
                             input logic [XW-1:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic add_case(input logic [XW-1:0] x, input logic [MW-1:0] m,
                          input logic [BLW-1:0] bl, input logic err);
    tab_x.push_back(x);
    tab_m.push_back(m);
    tab_bl.push_back(bl);
    tab_err.push_back(err);
  endtask

  task automatic add_mersenne(input int k, input logic [XW-1:0] x);
    add_case(x, MW'((64'd1 << k) - 64'd1), BLW'(k), 1'b0);   // m = 2^k - 1, bl = k
  endtask

  task automatic add_fermat(input int k, input logic [XW-1:0] x);
    add_case(x, MW'((64'd1 << k) + 64'd1), BLW'(k + 1), 1'b0);   // m = 2^k + 1, bl = k + 1
  endtask

  // Zero, m itself, an exact multiple, all ones and a single-beat value
  task automatic add_edge_cases(input logic [MW-1:0] m, input logic [BLW-1:0] bl);
    add_case('0, m, bl, 1'b0);
    add_case({32'b0, m}, m, bl, 1'b0);
    add_case({32'b0, m} * 64'd1000003, m, bl, 1'b0);
    add_case('1, m, bl, 1'b0);
    add_case({32'b0, m} - 64'd2, m, bl, 1'b0);
  endtask

  task automatic launch_request(input logic [XW-1:0] x, input logic [MW-1:0] m,
                                input logic [BLW-1:0] bl);
    x_i     = x;
    m_i     = m;
    m_bl_i  = bl;
    start_i = 1'b1;
    next_cycle();
    start_i = 1'b0;
  endtask

  task automatic wait_for_valid(output logic seen);
    int n;
    n = 0;
    while (!valid_o && n < TIMEOUT_CYCLES) begin
      next_cycle();
      n++;
    end
    seen = valid_o;
    if (!seen) begin
      $display("Timeout: valid_o did not pulse within %0d cycles", TIMEOUT_CYCLES);
      timeout_count++;
    end
  endtask

  task automatic wait_for_idle();
    int n;
    n = 0;
    while (busy_o && n < TIMEOUT_CYCLES) begin
      next_cycle();
      n++;
    end
    if (busy_o) begin
      $display("Timeout: busy_o stayed high, DUT never returned to idle");
      timeout_count++;
    end
  endtask

  task automatic run_case(input int idx);
    logic [XW-1:0] exp;
    logic          seen;
    exp = tab_err[idx] ? '0 : tab_x[idx] % {32'b0, tab_m[idx]};
    wait_for_idle();
    launch_request(tab_x[idx], tab_m[idx], tab_bl[idx]);
    check_value($sformatf("busy_o case %0d", idx), busy_o, 1);
    wait_for_valid(seen);
    if (seen) begin
      check_value($sformatf("result_o case %0d", idx), result_o, exp);
      check_value($sformatf("error_o case %0d", idx), error_o, tab_err[idx]);
      check_value($sformatf("busy_o at valid case %0d", idx), busy_o, 0);
    end
    next_cycle();
    check_value($sformatf("valid_o after pulse case %0d", idx), valid_o, 0);
  endtask

  initial begin
    int            k;
    int            valid_count;
    logic [31:0]   r;
    logic [XW-1:0] x;
    logic [XW-1:0] exp;
    logic          seen;

    start_i       = 1'b0;
    x_i           = '0;
    m_i           = '0;
    m_bl_i        = '0;
    rst_ni        = 1'b0;
    lcg_state     = LCG_SEED;
    err_count     = 0;
    timeout_count = 0;

    add_edge_cases(32'd7, 6'd3);
    add_edge_cases(32'h0000_1fff, 6'd13);
    add_edge_cases(32'hffff_ffff, 6'd32);
    add_edge_cases(32'd5, 6'd3);
    add_edge_cases(32'h0001_0001, 6'd17);
    add_edge_cases(32'h8000_0001, 6'd32);

    // Unsupported requests
    add_case(64'd12345, 32'd10, 6'd4, 1'b1);                 // Neither form
    add_case(64'd99, 32'd3, 6'd2, 1'b1);                     // bl below 3
    add_case(64'd99, 32'd7, 6'd33, 1'b1);                    // bl above 32
    add_case(64'hdead_beef_0123, 32'd7, 6'd63, 1'b1);
    add_case(64'hdead_beef_0123, 32'd7, 6'd4, 1'b1);         // bl does not match m
    add_case(64'h1234_5678_9abc, 32'd17, 6'd4, 1'b1);
    add_case(64'h1234_5678_9abc, 32'hffff_ffff, 6'd31, 1'b1);

    for (k = 3; k <= 32; k++) begin
      random_operand(x);
      add_mersenne(k, x);
    end
    for (k = 2; k <= 31; k++) begin
      random_operand(x);
      add_fermat(k, x);
    end

    // Random forms alternate between Mersenne and Fermat
    for (int i = 0; i < NUM_RANDOM; i++) begin
      random_operand(x);
      draw_random(r);
      if (i % 2 == 0) begin
        add_mersenne(3 + int'(r[15:8] % 30), x);
      end else begin
        add_fermat(2 + int'(r[15:8] % 30), x);
      end
    end

    repeat (RESET_CYCLES) next_cycle();
    rst_ni = 1'b1;

    repeat (3) begin
      check_value("valid_o after reset", valid_o, 0);
      check_value("error_o after reset", error_o, 0);
      check_value("busy_o after reset", busy_o, 0);
      check_value("result_o after reset", result_o, 0);
      next_cycle();
    end

    for (int i = 0; i < tab_x.size(); i++) begin
      run_case(i);
    end

    // Long request, 22 beats, with a second start pulsed while busy
    exp = 64'hffff_ffff_ffff_ffff % 64'd7;
    wait_for_idle();
    launch_request('1, 32'd7, 6'd3);
    next_cycle();
    check_value("busy_o before second start", busy_o, 1);
    launch_request(64'd12345, 32'd31, 6'd5);
    wait_for_valid(seen);
    if (seen) begin
      check_value("result_o with ignored start", result_o, exp);
      check_value("error_o with ignored start", error_o, 0);
      check_value("busy_o at valid", busy_o, 0);
    end
    valid_count = 0;
    repeat (40) begin
      next_cycle();
      if (valid_o) valid_count++;
    end
    check_value("valid_o extra pulses", valid_count, 0);
    check_value("busy_o after ignored start", busy_o, 0);
    check_value("result_o held", result_o, exp);

    $display("Checks done: %0d mismatches, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
logic/residue_pkg.sv
logic/chunk_stream_if.sv
logic/fold_sequencer.sv
logic/mersenne_fold.sv
logic/fermat_fold.sv
logic/residue_select.sv
logic/residue_top.sv
bench/residue_tb.sv

// ==== Bender.yml ====
package:
  name: residue_unit

sources:
  # Package first, then the interface, then the modules bottom up
  - files:
      - logic/residue_pkg.sv
      - logic/chunk_stream_if.sv
      - logic/fold_sequencer.sv
      - logic/mersenne_fold.sv
      - logic/fermat_fold.sv
      - logic/residue_select.sv
      - logic/residue_top.sv

  - target: simulation
    files:
      - bench/residue_tb.sv
